// ==== Makefile ====
VERILATOR := verilator
TOP       := cpu_top_tb
FILELIST  := cpu_top.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Mdir $(BUILD_DIR) --top-module $(TOP)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status is nonzero after $fatal
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== cpu_top.f ====
design/isa_pkg.sv
design/alu_pkg.sv
design/alu.sv
design/register_file.sv
design/pc_unit.sv
design/load_store_unit.sv
design/cpu_control.sv
design/cpu_top.sv
verif/cpu_top_properties.sv
verif/cpu_top_tb.sv

// ==== design/alu.sv ====
`default_nettype none

module alu #(
	parameter int data_width = 32
) (
	input  alu_pkg::alu_op_t       op,
	input  logic [data_width-1:0] src1,
	input  logic [data_width-1:0] src2,
	output logic [data_width-1:0] result,
	output logic                  zero,
	output logic                  ovf
);
	import alu_pkg::*;

	// operand and result sign bits
	logic sign_a;
	logic sign_b;
	logic sign_r;

	assign sign_a = src1[data_width-1];
	assign sign_b = src2[data_width-1];
	assign sign_r = result[data_width-1];

	// main datapath
	always_comb begin
		case (op)
			alu_add: begin
				result = src1 + src2;
			end
			alu_sub: begin
				result = src1 - src2;
			end
			alu_pass_a: begin
				result = src1;
			end
			default: begin
				// unused code, pass src1 through
				result = src1;
			end
		endcase
	end

	// signed overflow, add and sub only
	always_comb begin
		case (op)
			alu_add: begin
				// same operand signs, result sign flipped
				ovf = (sign_a == sign_b) && (sign_r != sign_a);
			end
			alu_sub: begin
				// operand signs differ, result sign flipped
				ovf = (sign_a != sign_b) && (sign_r != sign_a);
			end
			default: begin
				ovf = 1'b0;
			end
		endcase
	end

	// beq compares via sub, so zero is the equal flag
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	// alu operation select
	typedef enum logic [1:0] {
		alu_add    = 2'd0,
		alu_sub    = 2'd1,
		alu_pass_a = 2'd2
	} alu_op_t;

	// clears byte offset, gives word address
	localparam logic [31:0] word_mask = 32'hffff_fffc;

endpackage

`default_nettype wire

// ==== design/cpu_control.sv ====
`default_nettype none

module cpu_control (
	input  logic             clk,
	input  logic             arst_n,
	input  logic [31:0]      instr,
	input  logic             zero,
	input  logic             ovf,
	output alu_pkg::alu_op_t alu_op,
	output logic             rf_we,
	output logic [4:0]       rf_waddr,
	output logic [4:0]       rf_raddr_a,
	output logic [4:0]       rf_raddr_b,
	output logic             wb_sel,
	output logic             byte_op,
	output logic             mem_re,
	output logic             mem_we,
	output logic             pc_step,
	output logic             pc_load,
	output logic [16:0]      imm,
	output logic             overflow,
	output logic             illegal
);
	import isa_pkg::*;
	import alu_pkg::*;

	// sequencer, low is fetch and high is execute
	logic   exec;
	// instruction register
	instr_t ir;
	// decoded opcode class
	logic   is_arith;
	logic   is_mov;
	logic   is_load;
	logic   is_store;
	logic   is_beq;
	logic   is_jump;
	logic   is_known;
	logic   taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exec <= 1'b0;
		end else begin
			exec <= ~exec;
		end
	end

	// latch the fetched word at the end of fetch
	always_ff @(posedge clk) begin
		if (!exec) begin
			ir <= instr;
		end
	end

	// opcode classes
	assign is_arith = (ir.r.opcode == op_add) || (ir.r.opcode == op_sub);
	assign is_mov   = (ir.r.opcode == op_mov);
	assign is_load  = (ir.i.opcode == op_ldb) || (ir.i.opcode == op_ldw);
	assign is_store = (ir.i.opcode == op_stb) || (ir.i.opcode == op_stw);
	assign is_beq   = (ir.i.opcode == op_beq);
	assign is_jump  = (ir.i.opcode == op_jump);
	assign is_known = is_arith || is_mov || is_load || is_store || is_beq || is_jump;

	// register addresses
	// stores and beq read rd on port b, r-format reads rs2
	assign rf_raddr_a = ir.r.rs1;
	assign rf_raddr_b = (is_store || is_beq) ? ir.i.rd : ir.r.rs2;
	assign rf_waddr   = ir.r.rd;

	// alu op: sub for beq compare, add for address calc
	always_comb begin
		if (ir.r.opcode == op_sub || is_beq) begin
			alu_op = alu_sub;
		end else if (is_mov) begin
			alu_op = alu_pass_a;
		end else begin
			alu_op = alu_add;
		end
	end

	// memory side, strobes only in execute
	assign byte_op = (ir.i.opcode == op_ldb) || (ir.i.opcode == op_stb);
	assign mem_re  = exec && is_load;
	assign mem_we  = exec && is_store;
	assign wb_sel  = is_load;

	// writeback, dropped on signed overflow
	assign rf_we    = exec && (is_mov || is_load || (is_arith && !ovf));
	assign overflow = exec && is_arith && ovf;
	// unknown opcode, no-op apart from the pulse
	assign illegal  = exec && !is_known;

	// next pc
	assign taken   = is_jump || (is_beq && zero);
	assign imm     = ir.i.imm;
	assign pc_load = exec && taken;
	assign pc_step = exec && !taken;

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`default_nettype none

module cpu_top #(
	parameter int data_width = 32,
	parameter int pc_width   = 10
) (
	input  logic                clk,
	input  logic                arst_n,
	output logic [pc_width-1:0] imem_addr,
	input  logic [31:0]         imem_rdata,
	output logic [31:0]         dmem_addr,
	output logic [3:0]          dmem_be,
	output logic                dmem_we,
	output logic                dmem_re,
	output logic [31:0]         dmem_wdata,
	input  logic [31:0]         dmem_rdata,
	output logic                overflow,
	output logic                illegal
);
	import alu_pkg::*;

	// control to datapath
	alu_op_t               alu_op;
	logic                  rf_we;
	logic [4:0]            rf_waddr;
	logic [4:0]            rf_raddr_a;
	logic [4:0]            rf_raddr_b;
	logic                  wb_sel;
	logic                  byte_op;
	logic                  pc_step;
	logic                  pc_load;
	logic [16:0]           imm;
	// alu operands and flags
	logic [data_width-1:0] alu_src2;
	logic [data_width-1:0] alu_result;
	logic                  alu_zero;
	logic                  alu_ovf;
	// register file ports
	logic [data_width-1:0] rf_rdata_a;
	logic [data_width-1:0] rf_rdata_b;
	logic [data_width-1:0] wb_data;
	// zero extended or full load word
	logic [31:0]           load_data;

	// memory accesses add the immediate, everything else reads port b
	assign alu_src2 = (dmem_re || dmem_we) ? data_width'($signed(imm)) : rf_rdata_b;

	// writeback mux
	assign wb_data = wb_sel ? load_data : alu_result;

	cpu_control ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.instr      (imem_rdata),
		.zero       (alu_zero),
		.ovf        (alu_ovf),
		.alu_op     (alu_op),
		.rf_we      (rf_we),
		.rf_waddr   (rf_waddr),
		.rf_raddr_a (rf_raddr_a),
		.rf_raddr_b (rf_raddr_b),
		.wb_sel     (wb_sel),
		.byte_op    (byte_op),
		.mem_re     (dmem_re),
		.mem_we     (dmem_we),
		.pc_step    (pc_step),
		.pc_load    (pc_load),
		.imm        (imm),
		.overflow   (overflow),
		.illegal    (illegal)
	);

	alu #(
		.data_width(data_width)
	) alu_core (
		.op     (alu_op),
		.src1   (rf_rdata_a),
		.src2   (alu_src2),
		.result (alu_result),
		.zero   (alu_zero),
		.ovf    (alu_ovf)
	);

	register_file #(
		.data_width(data_width)
	) regfile (
		.clk     (clk),
		.arst_n  (arst_n),
		.we      (rf_we),
		.waddr   (rf_waddr),
		.wdata   (wb_data),
		.raddr_a (rf_raddr_a),
		.raddr_b (rf_raddr_b),
		.rdata_a (rf_rdata_a),
		.rdata_b (rf_rdata_b)
	);

	// pc drives the fetch address directly
	pc_unit #(
		.pc_width(pc_width)
	) pc_gen (
		.clk    (clk),
		.arst_n (arst_n),
		.step   (pc_step),
		.load   (pc_load),
		.offset (imm),
		.pc     (imem_addr)
	);

	// alu result is the byte address, port b is the store data
	load_store_unit lsu (
		.addr       (alu_result),
		.store_data (rf_rdata_b),
		.byte_op    (byte_op),
		.rdata      (dmem_rdata),
		.mem_addr   (dmem_addr),
		.be         (dmem_be),
		.wdata      (dmem_wdata),
		.load_data  (load_data)
	);

endmodule

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// opcode in instruction bits 31:27
	// gaps in the numbering decode as illegal
	typedef enum logic [4:0] {
		op_add  = 5'd0,
		op_sub  = 5'd1,
		op_ldb  = 5'd3,
		op_ldw  = 5'd4,
		op_stb  = 5'd5,
		op_stw  = 5'd6,
		op_mov  = 5'd7,
		op_beq  = 5'd8,
		op_jump = 5'd9
	} opcode_t;

	// register format: add, sub, mov
	typedef struct packed {
		opcode_t     opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] unused;
	} instr_r_t;

	// immediate format: loads, stores, beq, jump
	typedef struct packed {
		opcode_t            opcode;
		logic [4:0]         rd;
		logic [4:0]         rs1;
		logic signed [16:0] imm;
	} instr_i_t;

	// one word, two views
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

endpackage

`default_nettype wire

// ==== design/load_store_unit.sv ====
`default_nettype none

module load_store_unit (
	input  logic [31:0] addr,
	input  logic [31:0] store_data,
	input  logic        byte_op,
	input  logic [31:0] rdata,
	output logic [31:0] mem_addr,
	output logic [3:0]  be,
	output logic [31:0] wdata,
	output logic [31:0] load_data
);
	import alu_pkg::*;

	// byte offset within the word
	logic [1:0] lane;
	// byte picked out of the read word
	logic [7:0] lane_byte;

	assign lane = addr[1:0];

	// memory only ever sees word addresses
	assign mem_addr = addr & word_mask;

	// store side
	always_comb begin
		if (byte_op) begin
			// replicate byte, enable selects the lane
			wdata = {4{store_data[7:0]}};
			be    = 4'b0001 << lane;
		end else begin
			wdata = store_data;
			be    = 4'b1111;
		end
	end

	// little endian lane extraction
	always_comb begin
		case (lane)
			2'd0: lane_byte = rdata[7:0];
			2'd1: lane_byte = rdata[15:8];
			2'd2: lane_byte = rdata[23:16];
			default: lane_byte = rdata[31:24];
		endcase
	end

	// load side, byte is zero extended
	assign load_data = byte_op ? {24'd0, lane_byte} : rdata;

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
`default_nettype none

module pc_unit #(
	parameter int pc_width = 10
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                step,
	input  logic                load,
	input  logic [16:0]         offset,
	output logic [pc_width-1:0] pc
);

	// sequential successor
	logic [pc_width-1:0] pc_seq;
	// offset sign extended or truncated to pc width
	logic [pc_width-1:0] offset_ext;

	assign pc_seq     = pc + pc_width'(1);
	assign offset_ext = pc_width'($signed(offset));

	// branch target is relative to pc+1
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (load) begin
			pc <= pc_seq + offset_ext;
		end else if (step) begin
			pc <= pc_seq;
		end
	end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file #(
	parameter int data_width = 32
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  we,
	input  logic [4:0]            waddr,
	input  logic [data_width-1:0] wdata,
	input  logic [4:0]            raddr_a,
	input  logic [4:0]            raddr_b,
	output logic [data_width-1:0] rdata_a,
	output logic [data_width-1:0] rdata_b
);

	// 32 general registers
	logic [data_width-1:0] regs [32];

	// write port, r0 never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	// async read ports
	// r0 stays zero after reset, no special case needed
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// ==== verif/cpu_top_properties.sv ====
`default_nettype none

module cpu_top_properties #(
	parameter int pc_width = 10
) (
	input logic                clk,
	input logic                arst_n,
	input logic [pc_width-1:0] imem_addr,
	input logic [31:0]         dmem_addr,
	input logic                dmem_we,
	input logic                dmem_re
);

	// load and store never share an execute cycle
	a_strobe_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(dmem_we && dmem_re))
		else $error("dmem_we and dmem_re high together");

	// a strobe lasts one cycle, the next cycle is always a fetch
	a_strobe_single: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_we || dmem_re) |=> !(dmem_we || dmem_re))
		else $error("data strobe high in two consecutive cycles");

	// word aligned while a strobe is up
	a_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_we || dmem_re) |-> (dmem_addr[1:0] == 2'b00))
		else $error("dmem_addr not word aligned during a strobe");

	// pc moves at most once per two cycles
	a_pc_rate: assert property (@(posedge clk) disable iff (!arst_n)
		!$stable(imem_addr) |=> $stable(imem_addr))
		else $error("imem_addr changed in two consecutive cycles");

endmodule

bind cpu_top cpu_top_properties #(
	.pc_width(pc_width)
) props (
	.clk(clk),
	.arst_n(arst_n),
	.imem_addr(imem_addr),
	.dmem_addr(dmem_addr),
	.dmem_we(dmem_we),
	.dmem_re(dmem_re)
);

`default_nettype wire

// ==== verif/cpu_top_tb.sv ====
`default_nettype none

module cpu_top_tb;
	import isa_pkg::*;
	import alu_pkg::*;

	localparam int pc_width = 10;
	localparam int timeout_cycles = 200;

	logic                clk;
	logic                arst_n;
	logic [pc_width-1:0] imem_addr;
	logic [31:0]         imem_rdata;
	logic [31:0]         dmem_addr;
	logic [3:0]          dmem_be;
	logic                dmem_we;
	logic                dmem_re;
	logic [31:0]         dmem_wdata;
	logic [31:0]         dmem_rdata;
	logic                overflow;
	logic                illegal;

	// program memory, byte data memory and its expected image
	logic [31:0] imem [1 << pc_width];
	logic [7:0]  dmem [1024];
	logic [7:0]  exp_mem [1024];
	// store seen on the falling edge, committed on the rising edge
	logic        st_pend;
	logic [31:0] st_addr;
	logic [3:0]  st_be;
	logic [31:0] st_data;
	// monitors
	int                  ovf_count;
	int                  ill_count;
	int                  load_count;
	int                  store_count;
	logic [pc_width-1:0] pc_trace [$];
	logic [31:0]         lfsr;

	// positional, in cpu_top port order
	cpu_top #(.data_width(32), .pc_width(pc_width)) uut (
		clk, arst_n, imem_addr, imem_rdata, dmem_addr, dmem_be,
		dmem_we, dmem_re, dmem_wdata, dmem_rdata, overflow, illegal
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		logic [9:0] a;
		a = 10'(addr & word_mask);
		return {dmem[a + 10'd3], dmem[a + 10'd2], dmem[a + 10'd1], dmem[a]};
	endfunction

	// memories answer in the same cycle
	always @(negedge clk) begin
		imem_rdata <= imem[imem_addr];
		dmem_rdata <= read_word(dmem_addr);
		st_pend    <= arst_n && dmem_we;
		st_addr    <= dmem_addr;
		st_be      <= dmem_be;
		st_data    <= dmem_wdata;
	end

	always @(posedge clk) begin
		if (st_pend) begin
			for (int b = 0; b < 4; b++) begin
				if (st_be[b]) begin
					dmem[10'(st_addr + b)] = st_data[8*b +: 8];
				end
			end
		end
	end

	// pulse counts and distinct pc sequence
	always @(negedge clk) begin
		if (arst_n) begin
			if (overflow) begin
				ovf_count++;
			end
			if (illegal) begin
				ill_count++;
			end
			if (dmem_re) begin
				load_count++;
			end
			if (dmem_we) begin
				store_count++;
			end
			if (pc_trace.size() == 0 || pc_trace[$] != imem_addr) begin
				pc_trace.push_back(imem_addr);
			end
		end
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] rword(input opcode_t op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		instr_t w;
		w.r = '{opcode: op, rd: rd, rs1: rs1, rs2: rs2, unused: 12'd0};
		return w;
	endfunction

	function automatic logic [31:0] iword(input opcode_t op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic signed [16:0] imm);
		instr_t w;
		w.i = '{opcode: op, rd: rd, rs1: rs1, imm: imm};
		return w;
	endfunction

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_value(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s %s: expected %h actual %h", test, what, expected, actual);
			abort_run();
		end
	endtask

	// core held in reset while memories are rewritten
	task automatic begin_test();
		@(negedge clk);
		arst_n <= 1'b0;
		for (int a = 0; a < (1 << pc_width); a++) begin
			imem[a] = iword(op_jump, 5'd0, 5'd0, 17'h1ffff);
		end
		// fill covers every address bit
		for (int a = 0; a < 1024; a++) begin
			dmem[a]    = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
			exp_mem[a] = dmem[a];
		end
	endtask

	task automatic preload_word(input logic [31:0] addr, input logic [31:0] value);
		for (int b = 0; b < 4; b++) begin
			dmem[10'(addr + b)]    = value[8*b +: 8];
			exp_mem[10'(addr + b)] = value[8*b +: 8];
		end
	endtask

	task automatic expect_word(input logic [31:0] addr, input logic [31:0] value);
		for (int b = 0; b < 4; b++) begin
			exp_mem[10'(addr + b)] = value[8*b +: 8];
		end
	endtask

	// release reset, run until the stop address
	task automatic run_program(input string test, input int stop);
		int cycles;
		repeat (2) @(negedge clk);
		ovf_count   = 0;
		ill_count   = 0;
		load_count  = 0;
		store_count = 0;
		pc_trace.delete();
		arst_n <= 1'b1;
		cycles = 0;
		while (imem_addr != pc_width'(stop)) begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("%s: pc never reached stop address %0d", test, stop);
				abort_run();
			end
		end
		// stop's own execute cycle, monitors settled
		@(negedge clk);
	endtask

	task automatic compare_results(input string test, input int ovf, input int ill,
			input int loads, input int stores);
		for (int a = 0; a < 1024; a++) begin
			compare_value(test, $sformatf("mem[%03h]", a), 32'(exp_mem[a]), 32'(dmem[a]));
		end
		compare_value(test, "overflow pulses", ovf, ovf_count);
		compare_value(test, "illegal pulses", ill, ill_count);
		compare_value(test, "loads", loads, load_count);
		compare_value(test, "stores", stores, store_count);
	endtask

	task automatic match_trace(input string test, input int exp_pc[$]);
		compare_value(test, "pc trace length", exp_pc.size(), pc_trace.size());
		foreach (exp_pc[k]) begin
			compare_value(test, $sformatf("pc step %0d", k), exp_pc[k], 32'(pc_trace[k]));
		end
	endtask

	// add, sub, mov on random operands that cannot overflow
	task automatic test_arith();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		for (int n = 0; n < 4; n++) begin
			begin_test();
			r = random_bits(30);
			a = {{2{r[29]}}, r[29:0]};
			r = random_bits(30);
			b = {{2{r[29]}}, r[29:0]};
			imem[0] = iword(op_ldw, 5'd1, 5'd0, 17'h00100);
			imem[1] = iword(op_ldw, 5'd2, 5'd0, 17'h00104);
			imem[2] = rword(op_add, 5'd3, 5'd1, 5'd2);
			imem[3] = rword(op_sub, 5'd4, 5'd1, 5'd2);
			imem[4] = rword(op_mov, 5'd5, 5'd1, 5'd2);
			imem[5] = iword(op_stw, 5'd3, 5'd0, 17'h00200);
			imem[6] = iword(op_stw, 5'd4, 5'd0, 17'h00204);
			imem[7] = iword(op_stw, 5'd5, 5'd0, 17'h00208);
			preload_word(32'h100, a);
			preload_word(32'h104, b);
			expect_word(32'h200, a + b);
			expect_word(32'h204, a - b);
			expect_word(32'h208, a);
			run_program("arith", 8);
			compare_results("arith", 0, 0, 2, 3);
		end
	endtask

	// destination keeps its old value on signed overflow
	task automatic test_overflow();
		logic [31:0] m1;
		logic [31:0] m2;
		begin_test();
		m1 = random_bits(32);
		m2 = random_bits(32);
		imem[0] = iword(op_ldw, 5'd1, 5'd0, 17'h00100);
		imem[1] = iword(op_ldw, 5'd2, 5'd0, 17'h00104);
		imem[2] = iword(op_ldw, 5'd3, 5'd0, 17'h00108);
		imem[3] = iword(op_ldw, 5'd6, 5'd0, 17'h0010c);
		imem[4] = iword(op_ldw, 5'd7, 5'd0, 17'h00110);
		// positive plus positive, negative minus positive
		imem[5] = rword(op_add, 5'd6, 5'd1, 5'd2);
		imem[6] = rword(op_sub, 5'd7, 5'd3, 5'd2);
		imem[7] = iword(op_stw, 5'd6, 5'd0, 17'h00200);
		imem[8] = iword(op_stw, 5'd7, 5'd0, 17'h00204);
		preload_word(32'h100, 32'h7fff_fff0);
		preload_word(32'h104, 32'h0000_0100);
		preload_word(32'h108, 32'h8000_0010);
		preload_word(32'h10c, m1);
		preload_word(32'h110, m2);
		expect_word(32'h200, m1);
		expect_word(32'h204, m2);
		run_program("overflow", 9);
		compare_results("overflow", 2, 0, 5, 2);
	endtask

	// byte lanes, zero extension, word accesses ignore addr[1:0]
	task automatic test_bytes();
		logic [31:0] v;
		logic [31:0] orig;
		logic [31:0] after;
		begin_test();
		v     = random_bits(32) | 32'h80;
		orig  = 32'h8a9b_c7e4;
		after = {orig[31:24], v[7:0], orig[15:0]};
		imem[0] = iword(op_ldw, 5'd1, 5'd0, 17'h00100);
		imem[1] = iword(op_ldw, 5'd2, 5'd0, 17'h00104);
		imem[2] = iword(op_stb, 5'd1, 5'd2, 17'h00002);
		imem[3] = iword(op_ldb, 5'd3, 5'd2, 17'h00001);
		imem[4] = iword(op_ldb, 5'd4, 5'd2, 17'h00002);
		imem[5] = iword(op_ldw, 5'd5, 5'd2, 17'h00003);
		imem[6] = iword(op_stw, 5'd3, 5'd0, 17'h00200);
		imem[7] = iword(op_stw, 5'd4, 5'd0, 17'h00204);
		imem[8] = iword(op_stw, 5'd5, 5'd0, 17'h0020b);
		preload_word(32'h100, v);
		preload_word(32'h104, 32'h300);
		preload_word(32'h300, orig);
		expect_word(32'h300, after);
		expect_word(32'h200, {24'd0, orig[15:8]});
		expect_word(32'h204, {24'd0, v[7:0]});
		expect_word(32'h208, after);
		run_program("bytes", 9);
		compare_results("bytes", 0, 0, 5, 4);
	endtask

	// beq taken and not taken, jumps both ways
	task automatic test_branch();
		logic [31:0] x;
		logic [31:0] r;
		int          pcs [$];
		begin_test();
		x = random_bits(32);
		r = random_bits(31);
		imem[0]  = iword(op_ldw, 5'd1, 5'd0, 17'h00100);
		imem[1]  = iword(op_ldw, 5'd2, 5'd0, 17'h00104);
		imem[2]  = iword(op_ldw, 5'd3, 5'd0, 17'h00108);
		imem[3]  = iword(op_beq, 5'd2, 5'd1, 17'h00001);
		imem[4]  = iword(op_stw, 5'd1, 5'd0, 17'h00200);
		imem[5]  = iword(op_beq, 5'd3, 5'd1, 17'h00002);
		imem[6]  = iword(op_stw, 5'd1, 5'd0, 17'h00204);
		imem[7]  = iword(op_jump, 5'd0, 5'd0, 17'h00003);
		imem[8]  = iword(op_stw, 5'd1, 5'd0, 17'h00208);
		imem[9]  = iword(op_stw, 5'd1, 5'd0, 17'h0020c);
		imem[10] = iword(op_jump, 5'd0, 5'd0, 17'h00002);
		imem[11] = iword(op_jump, 5'd0, 5'd0, -17'sd3);
		imem[12] = iword(op_stw, 5'd1, 5'd0, 17'h00210);
		preload_word(32'h100, x);
		preload_word(32'h104, x);
		// bit 0 always differs
		preload_word(32'h108, x ^ {r[30:0], 1'b1});
		expect_word(32'h204, x);
		expect_word(32'h20c, x);
		pcs = '{0, 1, 2, 3, 5, 6, 7, 11, 9, 10, 13};
		run_program("branch", 13);
		compare_results("branch", 0, 0, 3, 2);
		match_trace("branch", pcs);
	endtask

	// unknown opcodes act as no-ops apart from the pulse
	task automatic test_illegal();
		logic [31:0] x;
		int          pcs [$];
		begin_test();
		x = random_bits(32);
		imem[0] = iword(op_ldw, 5'd1, 5'd0, 17'h00100);
		imem[1] = {5'd2, 5'd1, 5'd1, 17'h00044};
		imem[2] = iword(op_stw, 5'd1, 5'd0, 17'h00200);
		imem[3] = {5'd31, 5'd1, 5'd0, 17'h00204};
		preload_word(32'h100, x);
		expect_word(32'h200, x);
		pcs = '{0, 1, 2, 3, 4};
		run_program("illegal", 4);
		compare_results("illegal", 0, 2, 1, 1);
		match_trace("illegal", pcs);
	endtask

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		imem_rdata = '0;
		dmem_rdata = '0;
		st_pend    = 1'b0;
		lfsr       = 32'hee438199;
		test_arith();
		test_overflow();
		test_bytes();
		test_branch();
		test_illegal();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire
